// ==== verilog/cache_be_pkg.sv ====
package cache_be_pkg;

   // Byte address and word width
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // Bytes per word and the byte offset inside a word
   localparam int NBYTES   = DATA_W / 8;
   localparam int NBYTES_W = $clog2(NBYTES);

   // Cache line geometry
   localparam int LINE_WORDS    = 4;
   localparam int WORD_OFFSET_W = $clog2(LINE_WORDS);

   // Address widths with the byte and word offsets removed
   localparam int LINE_ADDR_W = ADDR_W - NBYTES_W - WORD_OFFSET_W;
   localparam int WORD_ADDR_W = ADDR_W - NBYTES_W;

   // Write-through buffer sizing
   localparam int WBUF_DEPTH = 4;
   localparam int WBUF_PTR_W = $clog2(WBUF_DEPTH);

   // Word write from the front end, addressed by word
   typedef struct packed {
      logic [WORD_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]      wdata;
      logic [NBYTES-1:0]      wstrb;
   } wr_req_t;

   // Request on the memory port, byte address kept word aligned
   // A zero wstrb marks a read
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } be_req_t;

endpackage

// ==== verilog/cache_write_buffer.sv ====
`timescale 1ns/1ps

module cache_write_buffer (
   input  logic                  clk,
   input  logic                  reset,

   // Accepted front-end writes
   input  logic                  push,
   input  cache_be_pkg::wr_req_t push_req,
   output logic                  full,

   // Head of the queue toward the write channel
   output logic                  buf_valid,
   output cache_be_pkg::wr_req_t buf_req,
   input  logic                  buf_pop,
   output logic                  buf_empty
);

   cache_be_pkg::wr_req_t mem [cache_be_pkg::WBUF_DEPTH];

   logic [cache_be_pkg::WBUF_PTR_W-1:0] wr_ptr;
   logic [cache_be_pkg::WBUF_PTR_W-1:0] rd_ptr;
   logic [cache_be_pkg::WBUF_PTR_W:0]   count;

   logic do_push;
   logic do_pop;

   // Depth is a power of two, so the count MSB alone means full
   assign full      = count[cache_be_pkg::WBUF_PTR_W];
   assign buf_empty = (count == '0);
   assign buf_valid = ~buf_empty;
   assign buf_req   = mem[rd_ptr];

   assign do_push = push & ~full;
   assign do_pop  = buf_pop & buf_valid;

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_req;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leave the count alone
         case ({do_push, do_pop})
            2'b10: begin
               count <= count + 1'b1;
            end
            2'b01: begin
               count <= count - 1'b1;
            end
            default: begin
               count <= count;
            end
         endcase
      end
   end

endmodule

// ==== verilog/cache_write_channel.sv ====
`timescale 1ns/1ps

module cache_write_channel (
   input  logic                  clk,
   input  logic                  reset,

   // Issue permission from the back end arbiter
   input  logic                  start_ok,

   // Write buffer head
   input  logic                  buf_valid,
   input  cache_be_pkg::wr_req_t buf_req,
   output logic                  buf_pop,
   output logic                  idle,

   // Memory port side
   output logic                  be_valid,
   output cache_be_pkg::be_req_t be_req,
   input  logic                  be_ready
);

   typedef enum logic {
      W_IDLE,
      W_BUSY
   } state_t;

   state_t state;

   // Take the head entry only when the port is ours
   assign buf_pop  = (state == W_IDLE) & start_ok & buf_valid;
   assign idle     = (state == W_IDLE);
   assign be_valid = (state == W_BUSY);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= W_IDLE;
      end else begin
         case (state)
            W_IDLE: begin
               if (buf_pop) begin
                  state <= W_BUSY;
               end
            end
            default: begin
               if (be_ready) begin
                  state <= W_IDLE;
               end
            end
         endcase
      end
   end

   // Word address becomes a word aligned byte address
   always_ff @(posedge clk) begin
      if (buf_pop) begin
         be_req.addr  <= {buf_req.addr, {cache_be_pkg::NBYTES_W{1'b0}}};
         be_req.wdata <= buf_req.wdata;
         be_req.wstrb <= buf_req.wstrb;
      end
   end

endmodule

// ==== verilog/cache_read_channel.sv ====
`timescale 1ns/1ps

module cache_read_channel (
   input  logic                                    clk,
   input  logic                                    reset,

   // Ordering condition from the back end
   input  logic                                    start_ok,

   // Line refill request and returned words
   input  logic                                    replace_valid,
   input  logic [cache_be_pkg::LINE_ADDR_W-1:0]    replace_addr,
   output logic                                    replace,
   output logic                                    read_valid,
   output logic [cache_be_pkg::WORD_OFFSET_W-1:0]  read_addr,
   output logic [cache_be_pkg::DATA_W-1:0]         read_rdata,

   // Memory port side
   output logic                                    be_valid,
   output cache_be_pkg::be_req_t                   be_req,
   input  logic [cache_be_pkg::DATA_W-1:0]         be_rdata,
   input  logic                                    be_ready
);

   typedef enum logic {
      R_IDLE,
      R_FETCH
   } state_t;

   state_t state;

   logic [cache_be_pkg::LINE_ADDR_W-1:0]   line_addr;
   logic [cache_be_pkg::WORD_OFFSET_W-1:0] beat;
   logic                                   start;
   logic                                   last_beat;

   assign start     = (state == R_IDLE) & replace_valid & start_ok;
   // Line length is a power of two, so the last beat is all ones
   assign last_beat = &beat;

   assign replace  = (state == R_FETCH);
   assign be_valid = (state == R_FETCH);

   // Reads carry no data and a zero strobe
   assign be_req.addr  = {line_addr, beat, {cache_be_pkg::NBYTES_W{1'b0}}};
   assign be_req.wdata = '0;
   assign be_req.wstrb = '0;

   // Each word goes back in the cycle the memory returns it
   assign read_valid = replace & be_ready;
   assign read_addr  = beat;
   assign read_rdata = be_rdata;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= R_IDLE;
         beat  <= '0;
      end else begin
         case (state)
            R_IDLE: begin
               if (start) begin
                  state <= R_FETCH;
                  beat  <= '0;
               end
            end
            default: begin
               if (be_ready) begin
                  beat <= beat + 1'b1;
                  if (last_beat) begin
                     state <= R_IDLE;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         line_addr <= replace_addr;
      end
   end

endmodule

// ==== verilog/cache_back_end.sv ====
`timescale 1ns/1ps

module cache_back_end (
   input  logic                                    clk,
   input  logic                                    reset,

   // Write buffer
   input  logic                                    buf_valid,
   input  cache_be_pkg::wr_req_t                   buf_req,
   output logic                                    buf_pop,
   input  logic                                    buf_empty,

   // Line refill
   input  logic                                    replace_valid,
   input  logic [cache_be_pkg::LINE_ADDR_W-1:0]    replace_addr,
   output logic                                    replace,
   output logic                                    read_valid,
   output logic [cache_be_pkg::WORD_OFFSET_W-1:0]  read_addr,
   output logic [cache_be_pkg::DATA_W-1:0]         read_rdata,

   // Memory port
   output logic                                    be_valid,
   output cache_be_pkg::be_req_t                   be_req,
   input  logic [cache_be_pkg::DATA_W-1:0]         be_rdata,
   input  logic                                    be_ready
);

   cache_be_pkg::be_req_t be_req_read;
   cache_be_pkg::be_req_t be_req_write;
   logic                  be_valid_read;
   logic                  be_valid_write;
   logic                  write_idle;
   logic                  read_start_ok;
   logic                  write_start_ok;

   // A refill waits for every buffered write to drain
   assign read_start_ok  = buf_empty & write_idle;
   // Writes hold off while a refill is pending or running
   assign write_start_ok = ~replace & ~replace_valid;

   assign be_req   = be_valid_read ? be_req_read : be_req_write;
   assign be_valid = be_valid_read | be_valid_write;

   cache_read_channel read_fsm (
      .clk           (clk),
      .reset         (reset),
      .start_ok      (read_start_ok),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .be_valid      (be_valid_read),
      .be_req        (be_req_read),
      .be_rdata      (be_rdata),
      .be_ready      (be_ready)
   );

   cache_write_channel write_fsm (
      .clk       (clk),
      .reset     (reset),
      .start_ok  (write_start_ok),
      .buf_valid (buf_valid),
      .buf_req   (buf_req),
      .buf_pop   (buf_pop),
      .idle      (write_idle),
      .be_valid  (be_valid_write),
      .be_req    (be_req_write),
      .be_ready  (be_ready)
   );

endmodule

// ==== verilog/cache_memory_side.sv ====
`timescale 1ns/1ps

module cache_memory_side (
   input  logic                                    clk,
   input  logic                                    reset,

   // Front-end word writes
   input  logic                                    write_valid,
   input  cache_be_pkg::wr_req_t                   write_req,
   output logic                                    write_ready,

   // Front-end line refill
   input  logic                                    replace_valid,
   input  logic [cache_be_pkg::LINE_ADDR_W-1:0]    replace_addr,
   output logic                                    replace,
   output logic                                    read_valid,
   output logic [cache_be_pkg::WORD_OFFSET_W-1:0]  read_addr,
   output logic [cache_be_pkg::DATA_W-1:0]         read_rdata,

   // Memory port
   output logic                                    be_valid,
   output cache_be_pkg::be_req_t                   be_req,
   input  logic [cache_be_pkg::DATA_W-1:0]         be_rdata,
   input  logic                                    be_ready
);

   cache_be_pkg::wr_req_t buf_req;
   logic                  buf_full;
   logic                  buf_valid;
   logic                  buf_pop;
   logic                  buf_empty;
   logic                  buf_push;

   assign write_ready = ~buf_full;
   assign buf_push    = write_valid & write_ready;

   cache_write_buffer u_write_buffer (
      .clk       (clk),
      .reset     (reset),
      .push      (buf_push),
      .push_req  (write_req),
      .full      (buf_full),
      .buf_valid (buf_valid),
      .buf_req   (buf_req),
      .buf_pop   (buf_pop),
      .buf_empty (buf_empty)
   );

   cache_back_end u_back_end (
      .clk           (clk),
      .reset         (reset),
      .buf_valid     (buf_valid),
      .buf_req       (buf_req),
      .buf_pop       (buf_pop),
      .buf_empty     (buf_empty),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .be_valid      (be_valid),
      .be_req        (be_req),
      .be_rdata      (be_rdata),
      .be_ready      (be_ready)
   );

endmodule

// ==== test/cache_back_end_properties.sv ====
`timescale 1ns/1ps

module cache_back_end_properties (
   input logic                  clk,
   input logic                  reset,
   input logic                  be_valid,
   input cache_be_pkg::be_req_t be_req,
   input logic                  be_ready,
   input logic                  write_be_valid,
   input logic                  replace,
   input logic                  read_valid
);

   int         failures = 0;
   logic [2:0] beat_count;

   // Words returned so far in the running refill
   always_ff @(posedge clk) begin
      if (reset || !replace) begin
         beat_count <= '0;
      end else if (read_valid) begin
         beat_count <= beat_count + 1'b1;
      end
   end

   request_held: assert property (@(posedge clk) disable iff (reset)
      be_valid && !be_ready |=> be_valid && $stable(be_req))
   else begin
      failures++;
      $error("memory port request changed or dropped before be_ready");
   end

   idle_after_reset: assert property (@(posedge clk) reset |=> !be_valid)
   else begin
      failures++;
      $error("be_valid high in the cycle after reset");
   end

   reads_own_port: assert property (@(posedge clk) disable iff (reset)
      replace |-> !write_be_valid)
   else begin
      failures++;
      $error("write channel request on the port during a refill");
   end

   four_beats: assert property (@(posedge clk) disable iff (reset)
      $fell(replace) |-> beat_count == 3'd4)
   else begin
      failures++;
      $error("refill ended without exactly four returned words");
   end

endmodule

bind cache_back_end cache_back_end_properties u_back_end_properties (
   .clk            (clk),
   .reset          (reset),
   .be_valid       (be_valid),
   .be_req         (be_req),
   .be_ready       (be_ready),
   .write_be_valid (be_valid_write),
   .replace        (replace),
   .read_valid     (read_valid)
);

// ==== test/tb_cache_memory_side.sv ====
`timescale 1ns/1ps

module tb_cache_memory_side;

   // About 220 requests at no more than 16 cycles each, with wide margin
   localparam int TIMEOUT_CYCLES = 20000;
   localparam int unsigned SEED = 32'h0b88_0492;

   logic                                   clk = 1'b0;
   logic                                   reset;
   logic                                   write_valid;
   cache_be_pkg::wr_req_t                  write_req;
   logic                                   write_ready;
   logic                                   replace_valid;
   logic [cache_be_pkg::LINE_ADDR_W-1:0]   replace_addr;
   logic                                   replace;
   logic                                   read_valid;
   logic [cache_be_pkg::WORD_OFFSET_W-1:0] read_addr;
   logic [cache_be_pkg::DATA_W-1:0]        read_rdata;
   logic                                   be_valid;
   cache_be_pkg::be_req_t                  be_req;
   logic [cache_be_pkg::DATA_W-1:0]        be_rdata = '0;
   logic                                   be_ready = 1'b0;

   // Memory model and the expected state
   logic [31:0]           mem [64];
   logic [31:0]           ref_mem [64];
   logic [31:0]           line_snap [4];
   cache_be_pkg::wr_req_t exp_writes [$];
   cache_be_pkg::wr_req_t head;
   logic [cache_be_pkg::LINE_ADDR_W-1:0] refill_line = '0;
   logic [1:0]            beat_exp;
   logic                  stall;
   logic                  write_pending;
   logic                  exp_ready;
   logic                  after_reset;
   logic [31:0]           exp_addr;
   logic [5:0]            idx;
   logic                  timed_out = 1'b0;
   int wait_left;
   int in_buf;
   int new_issue;
   int accepted_total;
   int acked_total;
   int refill_mark = 0;
   int check_errors = 0;
   int reset_errors = 0;
   int cycle_count = 0;
   int n;
   int k;

   cache_memory_side u_cache_memory_side (
      .clk           (clk),
      .reset         (reset),
      .write_valid   (write_valid),
      .write_req     (write_req),
      .write_ready   (write_ready),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .be_valid      (be_valid),
      .be_req        (be_req),
      .be_rdata      (be_rdata),
      .be_ready      (be_ready)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] fill_word(input logic [5:0] addr);
      return {8'h5a, 2'b00, addr, 8'hc3, 2'b01, addr};
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] data,
                                               input logic [3:0]  strb);
      logic [31:0] merged;
      merged = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            merged[b*8 +: 8] = data[b*8 +: 8];
         end
      end
      return merged;
   endfunction

   function automatic cache_be_pkg::wr_req_t random_write();
      cache_be_pkg::wr_req_t req;
      logic [31:0]           r;
      r = $urandom_range(0, 63);
      req.addr = {24'b0, r[5:0]};
      req.wdata = $urandom();
      r = $urandom_range(1, 15);
      req.wstrb = r[3:0];
      return req;
   endfunction

   task automatic send_write(input cache_be_pkg::wr_req_t req);
      write_valid = 1'b1;
      write_req = req;
      while (!write_ready) begin
         @(posedge clk);
         #1;
      end
      @(posedge clk);
      #1;
      write_valid = 1'b0;
   endtask

   task automatic do_refill(input logic [cache_be_pkg::LINE_ADDR_W-1:0] line);
      // The buffer must be empty, though the last write may still wait on the port
      while (!((acked_total == accepted_total) ||
               ((acked_total + 1 == accepted_total) && be_valid && be_req.wstrb != '0))) begin
         @(posedge clk);
         #1;
      end
      for (int w = 0; w < 4; w++) begin
         line_snap[w] = ref_mem[{line[3:0], w[1:0]}];
      end
      refill_line = line;
      refill_mark = accepted_total;
      replace_valid = 1'b1;
      replace_addr = line;
      while (!replace) begin
         @(posedge clk);
         #1;
      end
      replace_valid = 1'b0;
      // This write waits in the buffer behind the refill
      send_write(random_write());
      while (replace) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic finish_run();
      int prop_errors;
      int total;
      prop_errors = u_cache_memory_side.u_back_end.u_back_end_properties.failures;
      total = check_errors + reset_errors + prop_errors + (timed_out ? 1 : 0);
      $display("Errors: %0d check, %0d reset, %0d property, %0d timeout",
               check_errors, reset_errors, prop_errors, timed_out ? 1 : 0);
      if (total == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   endtask

   // Memory answers one cycle after be_valid plus 0 to 3 wait cycles
   always @(posedge clk) begin
      #1;
      if (reset) begin
         for (int i = 0; i < 64; i++) begin
            mem[i] = fill_word(i[5:0]);
         end
         be_ready = 1'b0;
         wait_left = -1;
      end else if (be_ready) begin
         be_ready = 1'b0;
         wait_left = -1;
      end else if (be_valid && !stall) begin
         if (wait_left < 0) begin
            wait_left = $urandom_range(0, 3);
         end else if (wait_left > 0) begin
            wait_left--;
         end else begin
            idx = be_req.addr[7:2];
            if (be_req.wstrb != '0) begin
               mem[idx] = merge_bytes(mem[idx], be_req.wdata, be_req.wstrb);
            end else begin
               be_rdata = mem[idx];
            end
            be_ready = 1'b1;
         end
      end
   end

   always @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 64; i++) begin
            ref_mem[i] = fill_word(i[5:0]);
         end
         in_buf = 0;
         accepted_total = 0;
         acked_total = 0;
         write_pending = 1'b0;
         beat_exp = '0;
         after_reset = 1'b1;
      end else begin
         // Outputs idle in the first cycle after reset
         if (after_reset) begin
            assert (!be_valid && !replace && !read_valid && write_ready) else begin
               reset_errors++;
               $display(
                  "FAIL reset outputs: be_valid %h, replace %h, read_valid %h, write_ready %h",
                  be_valid, replace, read_valid, write_ready);
            end
            after_reset = 1'b0;
         end
         // A new write on the port means the buffer gave up its head a cycle ago
         new_issue = (be_valid && be_req.wstrb != '0 && !write_pending) ? 1 : 0;
         exp_ready = ((in_buf - new_issue) < cache_be_pkg::WBUF_DEPTH);
         assert (write_ready == exp_ready) else begin
            check_errors++;
            $display("FAIL write_ready: got %h, expected %h", write_ready, exp_ready);
         end
         in_buf = in_buf - new_issue;
         if (write_valid && write_ready) begin
            exp_writes.push_back(write_req);
            ref_mem[write_req.addr[5:0]] = merge_bytes(ref_mem[write_req.addr[5:0]],
                                                      write_req.wdata, write_req.wstrb);
            accepted_total++;
            in_buf++;
         end
         if (be_valid && be_req.wstrb == '0) begin
            assert (acked_total >= refill_mark) else begin
               check_errors++;
               $display("Read request seen before all earlier writes were acknowledged");
            end
         end
         if (be_valid && be_ready && be_req.wstrb != '0) begin
            assert (exp_writes.size() != 0) else begin
               check_errors++;
               $display("Write on the memory port with no accepted write left");
            end
            if (exp_writes.size() != 0) begin
               head = exp_writes.pop_front();
               exp_addr = {head.addr, 2'b00};
               assert (be_req.addr == exp_addr) else begin
                  check_errors++;
                  $display("FAIL be_req.addr: got %h, expected %h", be_req.addr, exp_addr);
               end
               assert (be_req.wdata == head.wdata) else begin
                  check_errors++;
                  $display("FAIL be_req.wdata: got %h, expected %h", be_req.wdata, head.wdata);
               end
               assert (be_req.wstrb == head.wstrb) else begin
                  check_errors++;
                  $display("FAIL be_req.wstrb: got %h, expected %h", be_req.wstrb, head.wstrb);
               end
               acked_total++;
            end
         end
         if (be_valid && be_ready && be_req.wstrb == '0) begin
            exp_addr = {refill_line, beat_exp, 2'b00};
            assert (be_req.addr == exp_addr) else begin
               check_errors++;
               $display("FAIL be_req.addr: got %h, expected %h", be_req.addr, exp_addr);
            end
         end
         if (read_valid) begin
            assert (read_addr == beat_exp) else begin
               check_errors++;
               $display("FAIL read_addr: got %h, expected %h", read_addr, beat_exp);
            end
            assert (read_rdata == line_snap[beat_exp]) else begin
               check_errors++;
               $display("FAIL read_rdata: got %h, expected %h", read_rdata,
                        line_snap[beat_exp]);
            end
            beat_exp = beat_exp + 1'b1;
         end
         write_pending = be_valid && be_req.wstrb != '0 && !be_ready;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         timed_out = 1'b1;
         finish_run();
      end
   end

   initial begin
      void'($urandom(SEED));
      reset = 1'b1;
      write_valid = 1'b0;
      write_req = '0;
      replace_valid = 1'b0;
      replace_addr = '0;
      stall = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      // Memory stalls while the buffer fills, then a sixth write waits on write_ready
      stall = 1'b1;
      for (n = 0; n < 5; n++) begin
         send_write(random_write());
      end
      write_req = random_write();
      write_valid = 1'b1;
      repeat (10) begin
         @(posedge clk);
         #1;
      end
      stall = 1'b0;
      send_write(write_req);

      for (n = 0; n < 20; n++) begin
         for (k = 0; k < 10; k++) begin
            send_write(random_write());
            repeat ($urandom_range(0, 2)) begin
               @(posedge clk);
               #1;
            end
         end
         do_refill({24'b0, 4'($urandom_range(0, 15))});
      end

      while (acked_total != accepted_total) begin
         @(posedge clk);
         #1;
      end
      repeat (4) @(posedge clk);
      finish_run();
   end

endmodule

// ==== cache_memory_side.f ====
verilog/cache_be_pkg.sv
verilog/cache_write_buffer.sv
verilog/cache_write_channel.sv
verilog/cache_read_channel.sv
verilog/cache_back_end.sv
verilog/cache_memory_side.sv
test/cache_back_end_properties.sv
test/tb_cache_memory_side.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cache memory side testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG" build.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_cache_memory_side -f cache_memory_side.f > build.log 2>&1 &&
   ./obj_dir/Vtb_cache_memory_side +verilator+error+limit+1000 > "$LOG" 2>&1

cat build.log "$LOG" 2>/dev/null | tail -n 40

grep -q "^PASS: all tests$" "$LOG" 2>/dev/null &&
   { echo "simulation passed"; exit 0; } ||
   { echo "simulation failed"; exit 1; }
